// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS = --lint-only -Wall --timing --timescale 1ns/100ps
TOP       = tb_hdc_item_gen
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF 'TEST PASSED' $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/axil_ctrl_regs.sv ====
`default_nettype none

module axil_ctrl_regs (
    input  wire                             AXIS_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire [hdc_pkg::axil_addr_w-1:0]  s_axi_awaddr,
    input  wire                             s_axi_awvalid,
    output logic                            s_axi_awready,
    input  wire [hdc_pkg::axil_data_w-1:0]  s_axi_wdata,
    input  wire                             s_axi_wvalid,
    output logic                            s_axi_wready,
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  wire                             s_axi_bready,
    input  wire [hdc_pkg::axil_addr_w-1:0]  s_axi_araddr,
    input  wire                             s_axi_arvalid,
    output logic                            s_axi_arready,
    output logic [hdc_pkg::axil_data_w-1:0] s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  wire                             s_axi_rready,
    output hdc_pkg::gen_ctrl_t              gen_ctrl,
    input  wire                             gen_done,
    input  wire hdc_pkg::hv_t               item_vec
);
    import hdc_pkg::*;

    axil_state_e            state;
    logic [axil_addr_w-1:2] wr_addr_q;
    logic [axil_data_w-1:0] wr_data_q;
    logic [axil_addr_w-1:2] rd_addr_q;
    logic                   wr_fire;
    logic [axil_addr_w-1:2] wr_addr;
    logic [axil_data_w-1:0] wr_data;
    logic                   gen;
    item_idx_t              item_memory_num;

    // ----------------------------------------
    // channel handshakes
    // ----------------------------------------
    assign s_axi_awready = (state == idle) || (state == got_w);
    assign s_axi_wready  = (state == idle) || (state == got_aw);
    // a pending write keeps the read waiting
    assign s_axi_arready = (state == idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == write_resp);
    assign s_axi_rvalid  = (state == read_resp);
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;

    // both halves of the write are in hand this cycle
    always_comb begin
        wr_fire = 1'b0;
        wr_addr = wr_addr_q;
        wr_data = wr_data_q;
        case (state)
            idle: begin
                wr_fire = s_axi_awvalid && s_axi_wvalid;
                wr_addr = s_axi_awaddr[axil_addr_w-1:2];
                wr_data = s_axi_wdata;
            end
            got_aw: begin
                wr_fire = s_axi_wvalid;
                wr_data = s_axi_wdata;
            end
            got_w: begin
                wr_fire = s_axi_awvalid;
                wr_addr = s_axi_awaddr[axil_addr_w-1:2];
            end
            default: begin
                wr_fire = 1'b0;
            end
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= idle;
        end
        else begin
            case (state)
                idle: begin
                    if (wr_fire) begin
                        state <= write_resp;
                    end
                    else if (s_axi_awvalid) begin
                        state <= got_aw;
                    end
                    else if (s_axi_wvalid) begin
                        state <= got_w;
                    end
                    else if (s_axi_arvalid) begin
                        state <= read_wait;
                    end
                end
                got_aw, got_w: begin
                    if (wr_fire) begin
                        state <= write_resp;
                    end
                end
                // hold until the master takes the response
                write_resp: begin
                    if (s_axi_bready) begin
                        state <= idle;
                    end
                end
                read_wait: begin
                    state <= read_resp;
                end
                read_resp: begin
                    if (s_axi_rready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // address and data latches
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            wr_addr_q <= s_axi_awaddr[axil_addr_w-1:2];
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wr_data_q <= s_axi_wdata;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            rd_addr_q <= s_axi_araddr[axil_addr_w-1:2];
        end
    end

    // ----------------------------------------
    // control registers
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen             <= 1'b0;
            item_memory_num <= '0;
        end
        else begin
            if (wr_fire && ({wr_addr, 2'b00} == reg_ctrl_off) && wr_data[0]) begin
                gen <= 1'b1;
            end
            if (wr_fire && ({wr_addr, 2'b00} == reg_num_off)) begin
                item_memory_num <= wr_data[item_idx_w-1:0];
            end
            // completion wins over a set in the same cycle
            if (gen_done) begin
                gen <= 1'b0;
            end
        end
    end

    assign gen_ctrl = '{gen: gen, item_memory_num: item_memory_num};

    // read mux, sampled once in read_wait
    always_ff @(posedge AXIS_ACLK) begin
        if (state == read_wait) begin
            case ({rd_addr_q, 2'b00})
                reg_ctrl_off: s_axi_rdata <= {{(axil_data_w-1){1'b0}}, gen};
                reg_num_off:  s_axi_rdata <= axil_data_w'(item_memory_num);
                reg_item_off: s_axi_rdata <= item_vec;
                default:      s_axi_rdata <= '0;
            endcase
        end
    end

    // one response channel busy at a time
    a_resp_excl: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid));

    // datapath only finishes a generation that is running
    a_done_in_gen: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen_done |-> gen);

endmodule

`default_nettype wire

// ==== design/hdc_item_gen_top.sv ====
`default_nettype none

module hdc_item_gen_top (
    input  wire                             AXIS_ACLK,
    input  wire                             S_AXI_ARESETN,

    // write address
    input  wire [hdc_pkg::axil_addr_w-1:0]  s_axi_awaddr,
    input  wire                             s_axi_awvalid,
    output logic                            s_axi_awready,
    // write data
    input  wire [hdc_pkg::axil_data_w-1:0]  s_axi_wdata,
    input  wire                             s_axi_wvalid,
    output logic                            s_axi_wready,
    // write response
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  wire                             s_axi_bready,
    // read address
    input  wire [hdc_pkg::axil_addr_w-1:0]  s_axi_araddr,
    input  wire                             s_axi_arvalid,
    output logic                            s_axi_arready,
    // read data
    output logic [hdc_pkg::axil_data_w-1:0] s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  wire                             s_axi_rready
);
    import hdc_pkg::*;

    gen_ctrl_t gen_ctrl;
    word_t     word;
    item_pos_t pos;
    hv_t       item_vec;
    logic      gen_done;

    // ----------------------------------------
    // control side
    // ----------------------------------------
    axil_ctrl_regs i_axil_ctrl_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .gen_ctrl      (gen_ctrl),
        .gen_done      (gen_done),
        .item_vec      (item_vec)
    );

    // ----------------------------------------
    // generator datapath
    // ----------------------------------------
    xorshift_prng i_xorshift_prng (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_ctrl      (gen_ctrl),
        .word          (word)
    );

    item_word_counter i_item_word_counter (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_ctrl      (gen_ctrl),
        .pos           (pos)
    );

    // selected item goes back to the register block
    item_vector_capture i_item_vector_capture (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_ctrl      (gen_ctrl),
        .word          (word),
        .pos           (pos),
        .item_vec      (item_vec),
        .gen_done      (gen_done)
    );

endmodule

`default_nettype wire

// ==== design/hdc_pkg.sv ====
`default_nettype none

package hdc_pkg;

    // ----------------------------------------
    // hypervector geometry
    // ----------------------------------------
    localparam int hv_dim       = 32;
    localparam int word_w       = 32;
    localparam int words_per_hv = hv_dim / word_w;
    localparam int word_idx_w   = (words_per_hv > 1) ? $clog2(words_per_hv) : 1;
    // up to 1024 items
    localparam int item_idx_w   = 10;

    // axi-lite bus
    localparam int axil_addr_w  = 12;
    localparam int axil_data_w  = 32;

    typedef logic [hv_dim-1:0]     hv_t;
    typedef logic [word_w-1:0]     word_t;
    typedef logic [item_idx_w-1:0] item_idx_t;
    typedef logic [word_idx_w-1:0] word_idx_t;

    // ----------------------------------------
    // register map and generator constants
    // ----------------------------------------
    localparam logic [axil_addr_w-1:0] reg_ctrl_off = 12'h000;
    localparam logic [axil_addr_w-1:0] reg_num_off  = 12'h004;
    localparam logic [axil_addr_w-1:0] reg_item_off = 12'h00C;

    // xorshift32 triple 13/17/5
    // x ^= x << 13, then x ^= x >> 17, then x ^= x << 5
    localparam int xs_shift_a = 13;
    localparam int xs_shift_b = 17;
    localparam int xs_shift_c = 5;
    // any nonzero value keeps the sequence alive
    localparam word_t xorshift_seed = 32'h2545_F491;

    typedef enum logic [2:0] {
        idle,
        got_aw,
        got_w,
        write_resp,
        read_wait,
        read_resp
    } axil_state_e;

    // register block to datapath
    typedef struct packed {
        logic      gen;
        item_idx_t item_memory_num;
    } gen_ctrl_t;

    // counter to capture
    typedef struct packed {
        word_idx_t word_idx;
        item_idx_t item_idx;
        logic      item_done;
    } item_pos_t;

endpackage

`default_nettype wire

// ==== design/item_vector_capture.sv ====
`default_nettype none

module item_vector_capture (
    input  wire                     AXIS_ACLK,
    input  wire                     S_AXI_ARESETN,
    input  wire hdc_pkg::gen_ctrl_t gen_ctrl,
    input  wire hdc_pkg::word_t     word,
    input  wire hdc_pkg::item_pos_t pos,
    output hdc_pkg::hv_t            item_vec,
    output logic                    gen_done
);
    import hdc_pkg::*;

    hv_t  build;
    hv_t  assembled;
    logic hit;

    // current word dropped into its slot, lowest word in lowest bits
    always_comb begin
        assembled = build;
        assembled[pos.word_idx * word_w +: word_w] = word;
    end

    // last word of the requested item
    assign hit = gen_ctrl.gen && pos.item_done &&
                 (pos.item_idx == gen_ctrl.item_memory_num);

    always_ff @(posedge AXIS_ACLK) begin
        build <= assembled;
    end

    // ----------------------------------------
    // latch and completion pulse
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            item_vec <= '0;
            gen_done <= 1'b0;
        end
        else begin
            gen_done <= hit;
            if (hit) begin
                item_vec <= assembled;
            end
        end
    end

    // gen drops right after, so no second hit
    a_done_pulse: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen_done |=> !gen_done);

endmodule

`default_nettype wire

// ==== design/item_word_counter.sv ====
`default_nettype none

module item_word_counter (
    input  wire                     AXIS_ACLK,
    input  wire                     S_AXI_ARESETN,
    input  wire hdc_pkg::gen_ctrl_t gen_ctrl,
    output hdc_pkg::item_pos_t      pos
);
    import hdc_pkg::*;

    word_idx_t word_cnt;
    item_idx_t item_cnt;
    logic      last_word;

    assign last_word = (word_cnt == word_idx_t'(words_per_hv - 1));

    // ----------------------------------------
    // word and item counters
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen_ctrl.gen) begin
            word_cnt <= '0;
            item_cnt <= '0;
        end
        else if (last_word) begin
            word_cnt <= '0;
            item_cnt <= item_cnt + 1'b1;
        end
        else begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // one cycle behind the counters
    // lines up with the word leaving the generator
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen_ctrl.gen) begin
            pos <= '0;
        end
        else begin
            pos.word_idx  <= word_cnt;
            pos.item_idx  <= item_cnt;
            pos.item_done <= last_word;
        end
    end

endmodule

`default_nettype wire

// ==== design/xorshift_prng.sv ====
`default_nettype none

module xorshift_prng (
    input  wire                AXIS_ACLK,
    input  wire                S_AXI_ARESETN,
    input  wire hdc_pkg::gen_ctrl_t gen_ctrl,
    output hdc_pkg::word_t     word
);
    import hdc_pkg::*;

    word_t state;

    // one xorshift32 step
    function automatic word_t xs_step(input word_t x);
        word_t y;
        y = x ^ (x << xs_shift_a);
        y = y ^ (y >> xs_shift_b);
        y = y ^ (y << xs_shift_c);
        return y;
    endfunction

    // parked on the seed between runs
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen_ctrl.gen) begin
            state <= xorshift_seed;
        end
        else begin
            state <= xs_step(state);
        end
    end

    // first new word appears the cycle after gen rises
    assign word = state;

    // zero is a fixed point of xorshift
    a_state_nonzero: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        state != '0);

endmodule

`default_nettype wire

// ==== test/tb_hdc_checker.sv ====
`default_nettype none

module tb_hdc_checker (
    input  wire                             AXIS_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire [hdc_pkg::axil_addr_w-1:0]  s_axi_awaddr,
    input  wire                             s_axi_awvalid,
    input  wire                             s_axi_awready,
    input  wire [hdc_pkg::axil_data_w-1:0]  s_axi_wdata,
    input  wire                             s_axi_wvalid,
    input  wire                             s_axi_wready,
    input  wire [1:0]                       s_axi_bresp,
    input  wire                             s_axi_bvalid,
    input  wire                             s_axi_bready,
    input  wire [hdc_pkg::axil_addr_w-1:0]  s_axi_araddr,
    input  wire                             s_axi_arvalid,
    input  wire                             s_axi_arready,
    input  wire [hdc_pkg::axil_data_w-1:0]  s_axi_rdata,
    input  wire [1:0]                       s_axi_rresp,
    input  wire                             s_axi_rvalid,
    input  wire                             s_axi_rready,
    input  wire [3:0]                       test_num,
    input  wire                             test_end,
    input  wire                             all_done,
    input  wire                             gen_stuck,
    output int                              error_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import hdc_pkg::*;

    // register model
    logic [item_idx_w-1:0]  num_model = '0;
    logic                   gen_pending = 1'b0;
    logic [hv_dim-1:0]      item_model = '0;
    logic [hv_dim-1:0]      item_next = '0;

    // write halves seen so far
    logic [axil_addr_w-1:0] aw_q = '0;
    logic [axil_data_w-1:0] w_q = '0;
    logic                   aw_have = 1'b0;
    logic                   w_have = 1'b0;
    int                     b_owed = 0;
    logic [axil_addr_w-1:0] rd_addrs[$];

    int errors = 0;
    int checks = 0;
    int checks_mark = 0;
    int errors_mark = 0;

    assign error_count = errors;

    // ----------------------------------------
    // reference model of the generator
    // ----------------------------------------
    // xorshift32 with shifts 13, 17, 5
    function automatic logic [word_w-1:0] next_word(input logic [word_w-1:0] x);
        logic [word_w-1:0] t;
        t = x ^ {x[word_w-14:0], 13'b0};
        t = t ^ {17'b0, t[word_w-1:17]};
        t = t ^ {t[word_w-6:0], 5'b0};
        return t;
    endfunction

    // item k holds words k*words_per_hv onward, first word lowest
    function automatic logic [hv_dim-1:0] predict_item(input int k);
        logic [word_w-1:0] w;
        logic [hv_dim-1:0] v;
        w = xorshift_seed;
        v = '0;
        for (int i = 0; i < (k + 1) * words_per_hv; i++) begin
            w = next_word(w);
            if (i >= k * words_per_hv) begin
                v[(i - k * words_per_hv) * word_w +: word_w] = w;
            end
        end
        return v;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1: return "reset values";
            2: return "count write and read back";
            3: return "unmapped offsets";
            4: return "generation completes";
            5: return "item vector";
            6: return "second generation";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare(input string name, input logic [axil_data_w-1:0] got,
                           input logic [axil_data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic flag_problem(input string msg);
        errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    // ----------------------------------------
    // bus monitor
    // ----------------------------------------
    // sampled mid low phase, where inputs and outputs are settled
    always @(negedge AXIS_ACLK) begin
        logic [axil_addr_w-1:0] ra;
        string                  sig;
        logic                   busy;
        #1;
        if (!S_AXI_ARESETN) begin
            // both responses idle during reset
            compare("s_axi_bvalid", 32'(s_axi_bvalid), '0);
            compare("s_axi_rvalid", 32'(s_axi_rvalid), '0);
        end
        else begin
            // readies follow the transfer in flight
            // a response owed or a read in progress blocks every channel
            busy = (b_owed != 0) || (rd_addrs.size() != 0);
            compare("s_axi_awready", 32'(s_axi_awready), 32'(!busy && !aw_have));
            compare("s_axi_wready", 32'(s_axi_wready), 32'(!busy && !w_have));
            if (busy || aw_have || w_have) begin
                compare("s_axi_arready", 32'(s_axi_arready), '0);
            end
            if (s_axi_bvalid && s_axi_bready) begin
                compare("s_axi_bresp", 32'(s_axi_bresp), '0);
                if (b_owed == 0) begin
                    flag_problem("write response arrived with no write outstanding");
                end
                else begin
                    b_owed--;
                end
            end
            if (s_axi_awvalid && s_axi_awready) begin
                aw_q    = s_axi_awaddr;
                aw_have = 1'b1;
            end
            if (s_axi_wvalid && s_axi_wready) begin
                w_q    = s_axi_wdata;
                w_have = 1'b1;
            end
            // write takes effect once both halves are in
            if (aw_have && w_have) begin
                aw_have = 1'b0;
                w_have  = 1'b0;
                b_owed++;
                case ({aw_q[axil_addr_w-1:2], 2'b00})
                    reg_ctrl_off: begin
                        if (w_q[0] && !gen_pending) begin
                            gen_pending = 1'b1;
                            item_next   = predict_item(int'(num_model));
                        end
                    end
                    reg_num_off: num_model = w_q[item_idx_w-1:0];
                    default: ;
                endcase
            end
            if (s_axi_arvalid && s_axi_arready) begin
                rd_addrs.push_back(s_axi_araddr);
            end
            if (s_axi_rvalid && s_axi_rready) begin
                if (rd_addrs.size() == 0) begin
                    flag_problem("read data arrived with no read outstanding");
                end
                else begin
                    ra  = rd_addrs.pop_front();
                    sig = $sformatf("s_axi_rdata @0x%03h", ra);
                    compare("s_axi_rresp", 32'(s_axi_rresp), '0);
                    case ({ra[axil_addr_w-1:2], 2'b00})
                        reg_ctrl_off: begin
                            if (gen_pending) begin
                                // gen may still be running, bits above 0 stay clear
                                compare(sig, {s_axi_rdata[axil_data_w-1:1], 1'b0}, '0);
                                if (!s_axi_rdata[0]) begin
                                    gen_pending = 1'b0;
                                    item_model  = item_next;
                                end
                            end
                            else begin
                                compare(sig, s_axi_rdata, '0);
                            end
                        end
                        reg_num_off:  compare(sig, s_axi_rdata, axil_data_w'(num_model));
                        reg_item_off: compare(sig, s_axi_rdata, item_model);
                        default:      compare(sig, s_axi_rdata, '0);
                    endcase
                end
            end
        end

        // ----------------------------------------
        // reporting
        // ----------------------------------------
        if (gen_stuck) begin
            flag_problem("gen bit still set after the polling limit");
        end
        if (test_end) begin
            $display("test %0d (%s): %0d checks, %0d errors", test_num,
                     test_name(int'(test_num)), checks - checks_mark, errors - errors_mark);
            checks_mark = checks;
            errors_mark = errors;
        end
        if (all_done) begin
            $display("total: %0d checks, %0d errors", checks, errors);
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_hdc_item_gen.sv ====
`default_nettype none

module tb_hdc_item_gen;
    timeunit 1ns;
    timeprecision 100ps;
    import hdc_pkg::*;

    localparam int n_tests     = 6;
    localparam int cycle_limit = n_tests * (64 * words_per_hv + 200);
    // a poll takes several cycles, so this is generous
    localparam int poll_limit  = 64 * words_per_hv + 40;

    logic                   AXIS_ACLK;
    logic                   S_AXI_ARESETN;
    logic [axil_addr_w-1:0] s_axi_awaddr;
    logic                   s_axi_awvalid;
    logic                   s_axi_awready;
    logic [axil_data_w-1:0] s_axi_wdata;
    logic                   s_axi_wvalid;
    logic                   s_axi_wready;
    logic [1:0]             s_axi_bresp;
    logic                   s_axi_bvalid;
    logic                   s_axi_bready;
    logic [axil_addr_w-1:0] s_axi_araddr;
    logic                   s_axi_arvalid;
    logic                   s_axi_arready;
    logic [axil_data_w-1:0] s_axi_rdata;
    logic [1:0]             s_axi_rresp;
    logic                   s_axi_rvalid;
    logic                   s_axi_rready;

    logic [3:0]             test_num;
    logic                   test_end;
    logic                   all_done;
    logic                   gen_stuck;
    int                     error_count;
    int unsigned            lcg_state = 45;

    hdc_item_gen_top i_hdc_item_gen_top (.*);

    tb_hdc_checker i_checker (.*);

    // ----------------------------------------
    // clock, random numbers, watchdog
    // ----------------------------------------
    initial begin
        AXIS_ACLK = 1'b0;
        forever #2 AXIS_ACLK = ~AXIS_ACLK;
    end

    function automatic int unsigned lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits of the lcg are the better ones
    function automatic int unsigned rand_below(input int unsigned n);
        return (lcg_step() >> 8) % n;
    endfunction

    initial begin
        repeat (cycle_limit) @(posedge AXIS_ACLK);
        $display("watchdog: run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ----------------------------------------
    // AXI-Lite master tasks
    // ----------------------------------------
    // order 0 sends AW and W together, 1 address first, 2 data first
    task automatic bus_write(input logic [axil_addr_w-1:0] addr,
                             input logic [axil_data_w-1:0] data, input int order);
        logic aw_done;
        logic w_done;
        logic b_done;
        int   lag;
        aw_done = 1'b0;
        w_done  = 1'b0;
        b_done  = 1'b0;
        lag     = int'(rand_below(3));
        @(negedge AXIS_ACLK);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = (order != 2);
        s_axi_wvalid  = (order != 1);
        while (!(aw_done && w_done)) begin
            #1;
            aw_done = aw_done || (s_axi_awvalid && s_axi_awready);
            w_done  = w_done || (s_axi_wvalid && s_axi_wready);
            @(negedge AXIS_ACLK);
            s_axi_awvalid = s_axi_awvalid && !aw_done;
            s_axi_wvalid  = s_axi_wvalid && !w_done;
            // the late half follows after a random gap
            if (lag > 0) begin
                lag--;
            end
            else begin
                s_axi_awvalid = !aw_done;
                s_axi_wvalid  = !w_done;
            end
        end
        // response under random back-pressure
        while (!b_done) begin
            s_axi_bready = (rand_below(4) != 0);
            #1;
            b_done = s_axi_bvalid && s_axi_bready;
            @(negedge AXIS_ACLK);
        end
        s_axi_bready = 1'b0;
    endtask

    task automatic bus_read(input logic [axil_addr_w-1:0] addr,
                            output logic [axil_data_w-1:0] data);
        logic done;
        done = 1'b0;
        data = '0;
        @(negedge AXIS_ACLK);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        while (!done) begin
            #1;
            done = s_axi_arready;
            @(negedge AXIS_ACLK);
        end
        s_axi_arvalid = 1'b0;
        done = 1'b0;
        while (!done) begin
            s_axi_rready = (rand_below(4) != 0);
            #1;
            done = s_axi_rvalid && s_axi_rready;
            data = s_axi_rdata;
            @(negedge AXIS_ACLK);
        end
        s_axi_rready = 1'b0;
    endtask

    task automatic finish_test();
        @(negedge AXIS_ACLK);
        test_end = 1'b1;
        @(negedge AXIS_ACLK);
        test_end = 1'b0;
    endtask

    // set the count, start gen, poll until it drops
    task automatic run_generation(input int count);
        logic [axil_data_w-1:0] rd;
        int                     polls;
        bus_write(reg_num_off, axil_data_w'(count), int'(rand_below(3)));
        bus_write(reg_ctrl_off, 32'h1, int'(rand_below(3)));
        polls = 0;
        rd    = 32'h1;
        while (rd[0] && polls < poll_limit) begin
            bus_read(reg_ctrl_off, rd);
            polls++;
        end
        if (rd[0]) begin
            @(negedge AXIS_ACLK);
            gen_stuck = 1'b1;
            @(negedge AXIS_ACLK);
            gen_stuck = 1'b0;
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [axil_data_w-1:0] rd;
        logic [axil_addr_w-1:0] addr;
        int                     count1;
        int                     count2;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        test_num      = 4'd0;
        test_end      = 1'b0;
        all_done      = 1'b0;
        gen_stuck     = 1'b0;
        repeat (5) @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;

        test_num = 4'd1;
        bus_read(reg_ctrl_off, rd);
        bus_read(reg_num_off, rd);
        bus_read(12'h008, rd);
        bus_read(reg_item_off, rd);
        finish_test();

        test_num = 4'd2;
        for (int i = 0; i < 12; i++) begin
            bus_write(reg_num_off, lcg_step(), i % 3);
            bus_read(reg_num_off, rd);
        end
        finish_test();

        // 0x08 and 0x0C first, then random offsets above the map
        test_num = 4'd3;
        for (int i = 0; i < 6; i++) begin
            if (i == 0) begin
                addr = 12'h008;
            end
            else if (i == 1) begin
                addr = reg_item_off;
            end
            else begin
                addr = {10'(4 + rand_below(1020)), 2'b00};
            end
            bus_write(addr, lcg_step(), i % 3);
            bus_read(addr, rd);
            bus_read(reg_num_off, rd);
            bus_read(reg_ctrl_off, rd);
        end
        finish_test();

        test_num = 4'd4;
        count1 = int'(rand_below(64));
        run_generation(count1);
        finish_test();

        test_num = 4'd5;
        bus_read(reg_item_off, rd);
        finish_test();

        // a different count, so a stale vector cannot match
        test_num = 4'd6;
        count2 = (count1 + 1 + int'(rand_below(63))) % 64;
        run_generation(count2);
        bus_read(reg_item_off, rd);
        bus_read(reg_num_off, rd);
        finish_test();

        @(negedge AXIS_ACLK);
        all_done = 1'b1;
        @(negedge AXIS_ACLK);
        all_done = 1'b0;
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end
        else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/hdc_pkg.sv
design/xorshift_prng.sv
design/item_word_counter.sv
design/item_vector_capture.sv
design/axil_ctrl_regs.sv
design/hdc_item_gen_top.sv
test/tb_hdc_checker.sv
test/tb_hdc_item_gen.sv
